/* hdl/eth_fcs_check_top.sv */
// ========================================
// Ethernet FCS checker, 64-bit stream in and out
// strips the FCS and flags bad frames through user and error_bad_fcs
// ========================================

module eth_fcs_check_top import eth_fcs_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  fcs_data_t s_data,
    input  fcs_keep_t s_keep,
    input  logic      s_valid,
    input  logic      s_last,
    input  logic      s_user,
    output logic      s_ready,

    output fcs_data_t m_data,
    output fcs_keep_t m_keep,
    output logic      m_valid,
    output logic      m_last,
    output logic      m_user,
    input  logic      m_ready,

    output logic      busy,
    output logic      error_bad_fcs
);

    logic s_fire;
    logic crc_valid;
    logic crc_good;
    logic crc_take;

    // both the CRC and the aligner see every accepted beat
    assign s_fire = s_valid && s_ready;

    fcs_stream_if aligned ();

    fcs_crc_engine crc_i (
        .clk       (clk),
        .rst       (rst),
        .s_data    (s_data),
        .s_keep    (s_keep),
        .s_last    (s_last),
        .s_fire    (s_fire),
        .crc_take  (crc_take),
        .crc_valid (crc_valid),
        .crc_good  (crc_good)
    );

    fcs_beat_aligner align_i (
        .clk     (clk),
        .rst     (rst),
        .s_data  (s_data),
        .s_keep  (s_keep),
        .s_valid (s_valid),
        .s_last  (s_last),
        .s_user  (s_user),
        .s_ready (s_ready),
        .out     (aligned.src),
        .busy    (busy)
    );

    fcs_result_merge merge_i (
        .clk           (clk),
        .rst           (rst),
        .in            (aligned.dst),
        .crc_valid     (crc_valid),
        .crc_good      (crc_good),
        .crc_take      (crc_take),
        .m_data        (m_data),
        .m_keep        (m_keep),
        .m_valid       (m_valid),
        .m_last        (m_last),
        .m_user        (m_user),
        .m_ready       (m_ready),
        .error_bad_fcs (error_bad_fcs)
    );

endmodule

/* hdl/eth_fcs_defines.svh */
// ========================================
// datapath and CRC-32 constants for the FCS checker
// include wherever widths or CRC values are needed
// ========================================

`ifndef ETH_FCS_DEFINES_SVH
`define ETH_FCS_DEFINES_SVH

// bytes per beat on the 64-bit datapath
`define FCS_DATA_BYTES 8

// reflected form of 32'h04c11db7
`define FCS_CRC_POLY 32'hedb88320
`define FCS_CRC_INIT 32'hffffffff

// state left after folding a good frame including its FCS
`define FCS_CRC_RESIDUE (~32'h2144df1c)

`define FCS_MIN_FRAME_BYTES 12

`endif

/* hdl/eth_fcs_pkg.sv */
// ========================================
// shared types and the bytewise CRC-32 step
// import into any block that carries beats or CRC state
// ========================================

`include "eth_fcs_defines.svh"

package eth_fcs_pkg;

    // one beat of data, lane 0 in the low byte
    typedef logic [`FCS_DATA_BYTES*8-1:0] fcs_data_t;

    // one bit per lane, contiguous from lane 0
    typedef logic [`FCS_DATA_BYTES-1:0] fcs_keep_t;

    // running CRC state
    typedef logic [31:0] crc32_t;

    // advance the CRC by one byte, lsb first
    // the state is kept uninverted, so a good frame ends on the residue
    function automatic crc32_t crc32_byte(
        input crc32_t     crc,
        input logic [7:0] data
    );
        crc32_t c;

        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ `FCS_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

/* hdl/fcs_beat_aligner.sv */
// ========================================
// delays the input stream by one beat and strips the 4 FCS bytes
// last and keep are re-marked on the new final beat
// ========================================

`include "eth_fcs_defines.svh"

module fcs_beat_aligner import eth_fcs_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  fcs_data_t s_data,
    input  fcs_keep_t s_keep,
    input  logic      s_valid,
    input  logic      s_last,
    input  logic      s_user,
    output logic      s_ready,

    fcs_stream_if.src out,

    output logic      busy
);

    logic      ready_en;
    logic      hold_valid;
    fcs_data_t hold_data;
    fcs_keep_t hold_keep;
    logic      hold_user;
    logic      tail_pending;

    logic      o_valid;
    fcs_data_t o_data;
    fcs_keep_t o_keep;
    logic      o_last;
    logic      o_user;

    logic      out_free;
    logic      s_fire;
    logic      tail_load;
    logic      short_last;

    assign out_free  = !o_valid || out.ready;
    // no input while the trimmed tail still waits for the output slot
    assign s_ready   = ready_en && !tail_pending && out_free;
    assign s_fire    = s_valid && s_ready;
    assign tail_load = tail_pending && out_free;

    // FCS fits in the last beat's lanes, so the held beat closes the frame
    assign short_last = s_last && !s_keep[4];

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_en     <= 1'b0;
            hold_valid   <= 1'b0;
            tail_pending <= 1'b0;
            o_valid      <= 1'b0;
        end else begin
            ready_en <= 1'b1;

            if (s_fire) begin
                hold_valid   <= !short_last;
                tail_pending <= s_last && s_keep[4];
            end else if (tail_load) begin
                hold_valid   <= 1'b0;
                tail_pending <= 1'b0;
            end

            if ((s_fire && hold_valid) || tail_load) begin
                o_valid <= 1'b1;
            end else if (out.ready) begin
                o_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_fire) begin
            hold_data <= s_data;
            // long last beat keeps only its payload lanes
            hold_keep <= s_last ? {4'b0000, s_keep[7:4]} : s_keep;
            hold_user <= s_user;
        end

        if (s_fire && hold_valid) begin
            o_data <= hold_data;
            o_keep <= short_last ? {s_keep[3:0], 4'b1111} : hold_keep;
            o_last <= short_last;
            o_user <= short_last && s_user;
        end else if (tail_load) begin
            o_data <= hold_data;
            o_keep <= hold_keep;
            o_last <= 1'b1;
            o_user <= hold_user;
        end
    end

    assign out.data  = o_data;
    assign out.keep  = o_keep;
    assign out.valid = o_valid;
    assign out.last  = o_last;
    assign out.user  = o_user;

    assign busy = hold_valid || o_valid;

    a_no_single_beat_frame: assert property (
        @(posedge clk) disable iff (rst)
        s_fire && s_last |-> hold_valid
    ) else $error("frame ended on its first beat, minimum is %0d bytes",
                  `FCS_MIN_FRAME_BYTES);

endmodule

/* hdl/fcs_crc_engine.sv */
// ========================================
// CRC-32 over every accepted byte of a frame
// holds a good/bad verdict per frame until the merger takes it
// ========================================

`include "eth_fcs_defines.svh"

module fcs_crc_engine import eth_fcs_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    input  fcs_data_t s_data,
    input  fcs_keep_t s_keep,
    input  logic      s_last,
    input  logic      s_fire,

    input  logic      crc_take,
    output logic      crc_valid,
    output logic      crc_good
);

    crc32_t crc_state;
    crc32_t crc_next;

    // fold kept lanes in order, lane 0 first on the wire
    always_comb begin
        crc_next = crc_state;
        for (int i = 0; i < `FCS_DATA_BYTES; i++) begin
            if (s_keep[i]) begin
                crc_next = crc32_byte(crc_next, s_data[8*i +: 8]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            crc_state <= `FCS_CRC_INIT;
            crc_valid <= 1'b0;
            crc_good  <= 1'b0;
        end else begin
            if (s_fire) begin
                // restart for the next frame once the last beat is in
                if (s_last) begin
                    crc_state <= `FCS_CRC_INIT;
                end else begin
                    crc_state <= crc_next;
                end
            end

            if (s_fire && s_last) begin
                crc_valid <= 1'b1;
                crc_good  <= (crc_next == `FCS_CRC_RESIDUE);
            end else if (crc_take) begin
                crc_valid <= 1'b0;
            end
        end
    end

    // the merger must have consumed the previous verdict first
    a_no_verdict_overrun: assert property (
        @(posedge clk) disable iff (rst)
        s_fire && s_last |-> !crc_valid
    ) else $error("new FCS verdict while the previous one is still pending");

    // partial keep only allowed on the closing beat
    a_full_keep_mid_frame: assert property (
        @(posedge clk) disable iff (rst)
        s_fire && !s_last |-> (s_keep == '1)
    ) else $error("partial keep on a beat that is not last");

endmodule

/* hdl/fcs_result_merge.sv */
// ========================================
// joins the CRC verdict to each frame's last beat
// drives the output stream through a two-entry skid buffer
// ========================================

module fcs_result_merge import eth_fcs_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    fcs_stream_if.dst in,

    input  logic      crc_valid,
    input  logic      crc_good,
    output logic      crc_take,

    output fcs_data_t m_data,
    output fcs_keep_t m_keep,
    output logic      m_valid,
    output logic      m_last,
    output logic      m_user,
    input  logic      m_ready,

    output logic      error_bad_fcs
);

    logic      ready_int_reg;
    logic      ready_early;
    logic      take;
    logic      user_int;

    logic      m_valid_next;
    fcs_data_t temp_data;
    fcs_keep_t temp_keep;
    logic      temp_valid;
    logic      temp_valid_next;
    logic      temp_last;
    logic      temp_user;

    logic      store_out;
    logic      store_temp;
    logic      temp_to_out;

    // a last beat waits here until its verdict is in
    assign in.ready = ready_int_reg && (!in.last || crc_valid);
    assign take     = in.valid && in.ready;

    assign crc_take      = take && in.last;
    assign error_bad_fcs = crc_take && !crc_good;
    assign user_int      = in.user || (in.last && !crc_good);

    // accept next cycle unless the temp slot could fill
    assign ready_early = m_ready || (!temp_valid && (!m_valid || !take));

    always_comb begin
        m_valid_next    = m_valid;
        temp_valid_next = temp_valid;
        store_out       = 1'b0;
        store_temp      = 1'b0;
        temp_to_out     = 1'b0;

        if (ready_int_reg) begin
            if (m_ready || !m_valid) begin
                m_valid_next = take;
                store_out    = 1'b1;
            end else begin
                temp_valid_next = take;
                store_temp      = 1'b1;
            end
        end else if (m_ready) begin
            // drain the skid slot
            m_valid_next    = temp_valid;
            temp_valid_next = 1'b0;
            temp_to_out     = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid       <= 1'b0;
            temp_valid    <= 1'b0;
            ready_int_reg <= 1'b0;
        end else begin
            m_valid       <= m_valid_next;
            temp_valid    <= temp_valid_next;
            ready_int_reg <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_out) begin
            m_data <= in.data;
            m_keep <= in.keep;
            m_last <= in.last;
            m_user <= user_int;
        end else if (temp_to_out) begin
            m_data <= temp_data;
            m_keep <= temp_keep;
            m_last <= temp_last;
            m_user <= temp_user;
        end

        if (store_temp) begin
            temp_data <= in.data;
            temp_keep <= in.keep;
            temp_last <= in.last;
            temp_user <= user_int;
        end
    end

    // the skid slot only fills while it is empty
    a_no_skid_overrun: assert property (
        @(posedge clk) disable iff (rst)
        store_temp && take |-> !temp_valid
    ) else $error("skid slot loaded while still holding a beat");

endmodule

/* hdl/fcs_stream_if.sv */
// ========================================
// aligned beat stream between aligner and merger
// src drives the beat, dst answers with ready
// ========================================

interface fcs_stream_if import eth_fcs_pkg::*; ();

    fcs_data_t data;
    fcs_keep_t keep;
    logic      valid;
    logic      ready;
    logic      last;
    logic      user;

    // valid holds until the beat is taken
    modport src (
        output data,
        output keep,
        output valid,
        output last,
        output user,
        input  ready
    );

    modport dst (
        input  data,
        input  keep,
        input  valid,
        input  last,
        input  user,
        output ready
    );

endinterface

/* tb/tb_eth_fcs_check.sv */
// ========================================
// random-frame testbench for the Ethernet FCS checker
// a byte-level model with its own CRC checks every output frame
// ========================================

module tb_eth_fcs_check import eth_fcs_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES  = 200;
    localparam int MIN_BYTES   = 12;
    localparam int MAX_BYTES   = 100;
    localparam int MAX_BEATS   = 13;
    localparam int CLK_PERIOD  = 10;
    localparam int WATCHDOG_NS = NUM_FRAMES * MAX_BEATS * 4 * CLK_PERIOD;

    logic      clk;
    logic      rst;
    fcs_data_t s_data;
    fcs_keep_t s_keep;
    logic      s_valid;
    logic      s_last;
    logic      s_user;
    logic      s_ready;
    fcs_data_t m_data;
    fcs_keep_t m_keep;
    logic      m_valid;
    logic      m_last;
    logic      m_user;
    logic      m_ready;
    logic      busy;
    logic      error_bad_fcs;

    integer     seed;
    logic [7:0] exp_bytes[$];
    int         exp_len[$];
    logic       exp_user[$];
    int         errors[1:6];
    string      test_name[1:6];
    int         bad_frames;
    int         bad_pulses;
    int         frames_out;
    int         out_frame_bytes;
    int         total_in_bytes;
    int         total_out_bytes;
    logic       stall_pending;
    logic [73:0] stall_word;

    eth_fcs_check_top dut_i (
        .clk           (clk),
        .rst           (rst),
        .s_data        (s_data),
        .s_keep        (s_keep),
        .s_valid       (s_valid),
        .s_last        (s_last),
        .s_user        (s_user),
        .s_ready       (s_ready),
        .m_data        (m_data),
        .m_keep        (m_keep),
        .m_valid       (m_valid),
        .m_last        (m_last),
        .m_user        (m_user),
        .m_ready       (m_ready),
        .busy          (busy),
        .error_bad_fcs (error_bad_fcs)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // reference reflected CRC-32 computed one bit at a time
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            fb = c[0] ^ b[k];
            c  = {1'b0, c[31:1]};
            if (fb) begin
                c = c ^ 32'hedb88320;
            end
        end
        return c;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic int rand_below(input int n);
        return {$random(seed)} % n;
    endfunction

    task automatic report_mismatch(input int t, input logic [73:0] expected,
                                   input logic [73:0] actual);
        $display("mismatch %s: expected %0h, actual %0h", test_name[t], expected, actual);
        errors[t]++;
    endtask

    task automatic report_failure(input int t, input string what);
        $display("error in %s: %s", test_name[t], what);
        errors[t]++;
    endtask

    task automatic print_result(input int t);
        if (errors[t] == 0) begin
            $display("test %0d %s: ok", t, test_name[t]);
        end else begin
            $display("test %0d %s: failed with %0d errors", t, test_name[t], errors[t]);
        end
    endtask

    // m_ready changes on every falling edge
    task automatic next_cycle();
        @(negedge clk);
        m_ready = (rand_below(4) != 0);
    endtask

    task automatic send_beat(input fcs_data_t data, input fcs_keep_t keep,
                             input logic last, input logic user);
        logic accepted;
        while (rand_below(4) == 0) begin
            s_valid = 1'b0;
            next_cycle();
        end
        s_data  = data;
        s_keep  = keep;
        s_last  = last;
        s_user  = user;
        s_valid = 1'b1;
        do begin
            @(posedge clk);
            accepted = s_ready;
            next_cycle();
        end while (!accepted);
        // an accepted beat always leaves a frame in progress
        if (busy !== 1'b1) begin
            report_failure(6, "busy low while a frame is in progress");
        end
        s_valid = 1'b0;
    endtask

    task automatic send_frame();
        logic [7:0]  frame[$];
        logic [31:0] crc;
        logic [7:0]  flip;
        int          pos;
        int          len;
        logic        user;
        logic        bad;
        fcs_data_t   data;
        fcs_keep_t   keep;
        len  = MIN_BYTES + rand_below(MAX_BYTES - MIN_BYTES + 1);
        user = (rand_below(8) == 0);
        bad  = (rand_below(4) == 0);
        crc  = 32'hffffffff;
        for (int i = 0; i < len - 4; i++) begin
            frame.push_back(rand_byte());
            crc = crc_step(crc, frame[i]);
            exp_bytes.push_back(frame[i]);
        end
        // FCS goes out inverted with the low byte first
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            frame.push_back(crc[8*i +: 8]);
        end
        if (bad) begin
            pos  = len - 4 + rand_below(4);
            flip = 8'h01 << rand_below(8);
            frame[pos] = frame[pos] ^ flip;
            bad_frames++;
        end
        exp_len.push_back(len - 4);
        exp_user.push_back(user || bad);
        total_in_bytes += len - 4;

        for (int b = 0; b < len; b += 8) begin
            for (int i = 0; i < 8; i++) begin
                if (b + i < len) begin
                    data[8*i +: 8] = frame[b + i];
                    keep[i]        = 1'b1;
                end else begin
                    // filler in unused lanes
                    data[8*i +: 8] = rand_byte();
                    keep[i]        = 1'b0;
                end
            end
            send_beat(data, keep, (b + 8 >= len), user);
        end
    endtask

    task automatic collect_beat();
        logic [7:0] want;
        if (m_keep == 0 || ((m_keep + 8'h01) & m_keep) != 0) begin
            report_failure(2, $sformatf("keep %b is not contiguous from lane 0", m_keep));
        end
        for (int i = 0; i < 8; i++) begin
            if (m_keep[i]) begin
                total_out_bytes++;
                out_frame_bytes++;
                if (exp_bytes.size() == 0) begin
                    report_failure(2, "output byte arrived with no payload byte left");
                end else begin
                    want = exp_bytes.pop_front();
                    if (m_data[8*i +: 8] !== want) begin
                        report_mismatch(2, want, m_data[8*i +: 8]);
                    end
                end
            end
        end
        if (m_last) begin
            if (exp_len.size() == 0) begin
                report_failure(2, "m_last seen with no frame outstanding");
            end else begin
                if (out_frame_bytes != exp_len[0]) begin
                    report_mismatch(2, exp_len[0], out_frame_bytes);
                end
                // drop what a short frame left behind
                for (int i = out_frame_bytes; i < exp_len[0] && exp_bytes.size() > 0; i++) begin
                    void'(exp_bytes.pop_front());
                end
                if (m_user !== exp_user[0]) begin
                    report_mismatch(3, exp_user[0], m_user);
                end
                void'(exp_len.pop_front());
                void'(exp_user.pop_front());
            end
            frames_out++;
            out_frame_bytes = 0;
        end
    endtask

    // output monitor sampling the pre-edge values
    always @(posedge clk) begin
        if (!rst) begin
            if (error_bad_fcs) begin
                bad_pulses++;
            end
            if (stall_pending) begin
                if (!m_valid) begin
                    report_failure(5, "m_valid dropped while m_ready was low");
                end else if ({m_data, m_keep, m_last, m_user} !== stall_word) begin
                    report_mismatch(5, stall_word, {m_data, m_keep, m_last, m_user});
                end
            end
            stall_pending = m_valid && !m_ready;
            stall_word    = {m_data, m_keep, m_last, m_user};
            if (m_valid && m_ready) begin
                collect_beat();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, %0d of %0d frames seen at the output",
                 WATCHDOG_NS, frames_out, NUM_FRAMES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int failed;
        seed            = 32'ha4d7;
        clk             = 1'b0;
        rst             = 1'b1;
        s_data          = '0;
        s_keep          = '0;
        s_valid         = 1'b0;
        s_last          = 1'b0;
        s_user          = 1'b0;
        m_ready         = 1'b0;
        bad_frames      = 0;
        bad_pulses      = 0;
        frames_out      = 0;
        out_frame_bytes = 0;
        total_in_bytes  = 0;
        total_out_bytes = 0;
        stall_pending   = 1'b0;
        stall_word      = '0;
        failed          = 0;
        test_name[1] = "reset_state";
        test_name[2] = "payload_bytes";
        test_name[3] = "final_user";
        test_name[4] = "bad_fcs_pulses";
        test_name[5] = "backpressure";
        test_name[6] = "drain_idle";
        for (int t = 1; t <= 6; t++) begin
            errors[t] = 0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        if (s_ready !== 1'b0 || m_valid !== 1'b0 || busy !== 1'b0 || error_bad_fcs !== 1'b0) begin
            report_failure(1, "outputs not low while reset is held");
        end
        rst = 1'b0;
        @(negedge clk);
        if (s_ready !== 1'b1) begin
            report_failure(1, "s_ready not high one cycle after reset");
        end
        if (m_valid !== 1'b0 || busy !== 1'b0 || error_bad_fcs !== 1'b0) begin
            report_failure(1, "m_valid, busy or error_bad_fcs high right after reset");
        end
        print_result(1);

        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame();
        end
        while (frames_out < NUM_FRAMES) begin
            next_cycle();
        end
        m_ready = 1'b1;
        repeat (2) @(negedge clk);

        if (exp_bytes.size() != 0) begin
            report_failure(2, "payload bytes never reached the output");
        end
        if (bad_pulses != bad_frames) begin
            report_mismatch(4, bad_frames, bad_pulses);
        end
        if (total_out_bytes != total_in_bytes) begin
            report_mismatch(5, total_in_bytes, total_out_bytes);
        end
        if (busy !== 1'b0 || m_valid !== 1'b0) begin
            report_failure(6, "busy or m_valid still high after the last frame drained");
        end
        for (int t = 2; t <= 6; t++) begin
            print_result(t);
        end
        for (int t = 1; t <= 6; t++) begin
            if (errors[t] != 0) begin
                failed++;
            end
        end
        $display("%0d tests passed, %0d failed, %0d frames, %0d bad frames",
                 6 - failed, failed, frames_out, bad_frames);
        if (failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+hdl
hdl/eth_fcs_pkg.sv
hdl/fcs_stream_if.sv
hdl/fcs_crc_engine.sv
hdl/fcs_beat_aligner.sv
hdl/fcs_result_merge.sv
hdl/eth_fcs_check_top.sv
tb/tb_eth_fcs_check.sv
